// File: source/store_pkg.sv
package store_pkg;

    // width of one write lane in bits.
    localparam int byte_len = 8;

    // client request type. a write returns the old entry as well.
    typedef enum logic
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } store_op_e;

    // client that wins the next tie on port A.
    typedef enum logic
    {
        prio_client0 = 1'b0,
        prio_client1 = 1'b1
    } prio_e;

endpackage

// File: source/dual_port_blockram.sv
`timescale 1ns/1ps

module dual_port_blockram
    import store_pkg::*;
#(
    parameter int ENTRY_BITS = 64,
    parameter int NUM_SET    = 64
)
(
    input  logic                               clk_in,
    input  logic                               reset_in,

    input  logic                               a_en,
    input  logic [ENTRY_BITS / byte_len - 1:0] a_mask,
    input  logic [$clog2(NUM_SET) - 1:0]       a_addr,
    input  logic [ENTRY_BITS - 1:0]            a_wdata,
    output logic [ENTRY_BITS - 1:0]            a_rdata,
    output logic                               a_hit,

    input  logic                               b_en,
    input  logic [ENTRY_BITS / byte_len - 1:0] b_mask,
    input  logic [$clog2(NUM_SET) - 1:0]       b_addr,
    input  logic [ENTRY_BITS - 1:0]            b_wdata,
    output logic [ENTRY_BITS - 1:0]            b_rdata,
    output logic                               b_hit
);

    localparam int MASK_BITS = ENTRY_BITS / byte_len;

    logic [ENTRY_BITS - 1:0] ram [NUM_SET];
    logic [NUM_SET - 1:0]    valid_q;

    logic a_write;
    logic b_write;

    assign a_write = a_en & (|a_mask);
    assign b_write = b_en & (|b_mask);

    // both ports share the array. reads see the contents from before this edge.
    always_ff @(posedge clk_in)
    begin
        if (a_en)
        begin
            for (int lane = 0; lane < MASK_BITS; lane++)
            begin
                if (a_mask[lane])
                begin
                    ram[a_addr][lane * byte_len +: byte_len] <=
                        a_wdata[lane * byte_len +: byte_len];
                end
            end
            a_rdata <= ram[a_addr];
        end

        if (b_en)
        begin
            for (int lane = 0; lane < MASK_BITS; lane++)
            begin
                if (b_mask[lane])
                begin
                    ram[b_addr][lane * byte_len +: byte_len] <=
                        b_wdata[lane * byte_len +: byte_len];
                end
            end
            b_rdata <= ram[b_addr];
        end
    end

    // valid bits. any write with a lane enabled marks the set.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (a_write)
            begin
                valid_q[a_addr] <= 1'b1;
            end
            if (b_write)
            begin
                valid_q[b_addr] <= 1'b1;
            end
        end
    end

    // hit flags carry the old valid bit, low when the port was idle.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            a_hit <= 1'b0;
            b_hit <= 1'b0;
        end
        else
        begin
            a_hit <= a_en & valid_q[a_addr];
            b_hit <= b_en & valid_q[b_addr];
        end
    end

endmodule

// File: source/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter
    import store_pkg::*;
#(
    parameter int ENTRY_BITS = 64,
    parameter int NUM_SET    = 64
)
(
    input  logic                               clk_in,
    input  logic                               reset_in,

    input  logic                               c0_req,
    input  store_op_e                          c0_op,
    input  logic [$clog2(NUM_SET) - 1:0]       c0_addr,
    input  logic [ENTRY_BITS / byte_len - 1:0] c0_mask,
    input  logic [ENTRY_BITS - 1:0]            c0_wdata,

    input  logic                               c1_req,
    input  store_op_e                          c1_op,
    input  logic [$clog2(NUM_SET) - 1:0]       c1_addr,
    input  logic [ENTRY_BITS / byte_len - 1:0] c1_mask,
    input  logic [ENTRY_BITS - 1:0]            c1_wdata,

    output logic                               c0_grant,
    output logic                               c1_grant,

    output logic                               a_en,
    output logic [ENTRY_BITS / byte_len - 1:0] a_mask,
    output logic [$clog2(NUM_SET) - 1:0]       a_addr,
    output logic [ENTRY_BITS - 1:0]            a_wdata,

    output logic                               win_id,
    output logic                               win_en
);

    localparam int MASK_BITS = ENTRY_BITS / byte_len;

    prio_e                  prio_q;
    store_op_e              win_op;
    logic [MASK_BITS - 1:0] win_mask;

    // a lone requester wins at once, a tie goes to the priority holder.
    assign c0_grant = c0_req & (~c1_req | (prio_q == prio_client0));
    assign c1_grant = c1_req & (~c0_req | (prio_q == prio_client1));

    assign win_en = c0_grant | c1_grant;
    assign win_id = c1_grant;

    always_comb
    begin
        if (c1_grant)
        begin
            win_op   = c1_op;
            win_mask = c1_mask;
            a_addr   = c1_addr;
            a_wdata  = c1_wdata;
        end
        else
        begin
            win_op   = c0_op;
            win_mask = c0_mask;
            a_addr   = c0_addr;
            a_wdata  = c0_wdata;
        end
    end

    // reads never touch a lane.
    assign a_en   = win_en;
    assign a_mask = (win_op == op_write) ? win_mask : '0;

    // priority passes to the other client after every grant.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            prio_q <= prio_client0;
        end
        else if (c0_grant)
        begin
            prio_q <= prio_client1;
        end
        else if (c1_grant)
        begin
            prio_q <= prio_client0;
        end
    end

endmodule

// File: source/response_router.sv
`timescale 1ns/1ps

module response_router
#(
    parameter int ENTRY_BITS = 64
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    input  logic                    win_id,
    input  logic                    win_en,
    input  logic [ENTRY_BITS - 1:0] a_rdata,
    input  logic                    a_hit,

    output logic                    c0_rsp_valid,
    output logic [ENTRY_BITS - 1:0] c0_rdata,
    output logic                    c0_hit,

    output logic                    c1_rsp_valid,
    output logic [ENTRY_BITS - 1:0] c1_rdata,
    output logic                    c1_hit
);

    logic pending_q;
    logic owner_q;

    // owner of the access now in the store, one stage deep.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            pending_q <= 1'b0;
            owner_q   <= 1'b0;
        end
        else
        begin
            pending_q <= win_en;
            owner_q   <= win_id;
        end
    end

    assign c0_rsp_valid = pending_q & ~owner_q;
    assign c1_rsp_valid = pending_q & owner_q;

    // data goes to both, hit only to the owner.
    assign c0_rdata = a_rdata;
    assign c1_rdata = a_rdata;
    assign c0_hit   = c0_rsp_valid & a_hit;
    assign c1_hit   = c1_rsp_valid & a_hit;

endmodule

// File: source/shared_store_top.sv
`timescale 1ns/1ps

module shared_store_top
    import store_pkg::*;
#(
    parameter int ENTRY_BITS = 64,
    parameter int NUM_SET    = 64
)
(
    input  logic                               clk_in,
    input  logic                               reset_in,

    input  logic                               c0_req,
    input  store_op_e                          c0_op,
    input  logic [$clog2(NUM_SET) - 1:0]       c0_addr,
    input  logic [ENTRY_BITS / byte_len - 1:0] c0_mask,
    input  logic [ENTRY_BITS - 1:0]            c0_wdata,
    output logic                               c0_grant,
    output logic                               c0_rsp_valid,
    output logic [ENTRY_BITS - 1:0]            c0_rdata,
    output logic                               c0_hit,

    input  logic                               c1_req,
    input  store_op_e                          c1_op,
    input  logic [$clog2(NUM_SET) - 1:0]       c1_addr,
    input  logic [ENTRY_BITS / byte_len - 1:0] c1_mask,
    input  logic [ENTRY_BITS - 1:0]            c1_wdata,
    output logic                               c1_grant,
    output logic                               c1_rsp_valid,
    output logic [ENTRY_BITS - 1:0]            c1_rdata,
    output logic                               c1_hit,

    input  logic                               b_en,
    input  logic [ENTRY_BITS / byte_len - 1:0] b_mask,
    input  logic [$clog2(NUM_SET) - 1:0]       b_addr,
    input  logic [ENTRY_BITS - 1:0]            b_wdata,
    output logic [ENTRY_BITS - 1:0]            b_rdata,
    output logic                               b_hit,
    output logic                               b_rsp_valid
);

    localparam int ADDR_BITS = $clog2(NUM_SET);
    localparam int MASK_BITS = ENTRY_BITS / byte_len;

    logic                    a_en;
    logic [MASK_BITS - 1:0]  a_mask;
    logic [ADDR_BITS - 1:0]  a_addr;
    logic [ENTRY_BITS - 1:0] a_wdata;
    logic [ENTRY_BITS - 1:0] a_rdata;
    logic                    a_hit;
    logic                    win_id;
    logic                    win_en;

    port_arbiter #(
        .ENTRY_BITS (ENTRY_BITS),
        .NUM_SET    (NUM_SET)
    ) u_arbiter (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .c0_req   (c0_req),
        .c0_op    (c0_op),
        .c0_addr  (c0_addr),
        .c0_mask  (c0_mask),
        .c0_wdata (c0_wdata),
        .c1_req   (c1_req),
        .c1_op    (c1_op),
        .c1_addr  (c1_addr),
        .c1_mask  (c1_mask),
        .c1_wdata (c1_wdata),
        .c0_grant (c0_grant),
        .c1_grant (c1_grant),
        .a_en     (a_en),
        .a_mask   (a_mask),
        .a_addr   (a_addr),
        .a_wdata  (a_wdata),
        .win_id   (win_id),
        .win_en   (win_en)
    );

    response_router #(
        .ENTRY_BITS (ENTRY_BITS)
    ) u_router (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .win_id       (win_id),
        .win_en       (win_en),
        .a_rdata      (a_rdata),
        .a_hit        (a_hit),
        .c0_rsp_valid (c0_rsp_valid),
        .c0_rdata     (c0_rdata),
        .c0_hit       (c0_hit),
        .c1_rsp_valid (c1_rsp_valid),
        .c1_rdata     (c1_rdata),
        .c1_hit       (c1_hit)
    );

    dual_port_blockram #(
        .ENTRY_BITS (ENTRY_BITS),
        .NUM_SET    (NUM_SET)
    ) u_store (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .a_en     (a_en),
        .a_mask   (a_mask),
        .a_addr   (a_addr),
        .a_wdata  (a_wdata),
        .a_rdata  (a_rdata),
        .a_hit    (a_hit),
        .b_en     (b_en),
        .b_mask   (b_mask),
        .b_addr   (b_addr),
        .b_wdata  (b_wdata),
        .b_rdata  (b_rdata),
        .b_hit    (b_hit)
    );

    // port B answers one cycle after its enable.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            b_rsp_valid <= 1'b0;
        end
        else
        begin
            b_rsp_valid <= b_en;
        end
    end

endmodule

// File: test/store_tb_util.svh
`ifndef STORE_TB_UTIL_SVH
`define STORE_TB_UTIL_SVH

logic [31:0]             rng_state;
logic [ENTRY_BITS - 1:0] model_data  [NUM_SET];
logic [MASK_BITS - 1:0]  model_known [NUM_SET];
logic                    model_valid [NUM_SET];
prio_e                   model_prio;

// xorshift32, one step per call.
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// one byte lane of ones per set mask bit.
function automatic logic [ENTRY_BITS - 1:0] expand_lanes(input logic [MASK_BITS - 1:0] mask);
    logic [ENTRY_BITS - 1:0] bits;
    bits = '0;
    for (int lane = 0; lane < MASK_BITS; lane++)
    begin
        if (mask[lane])
        begin
            bits[lane * byte_len +: byte_len] = '1;
        end
    end
    return bits;
endfunction

// merge the masked lanes into the model entry.
task automatic apply_write(
    input logic [ADDR_BITS - 1:0]  addr,
    input logic [MASK_BITS - 1:0]  mask,
    input logic [ENTRY_BITS - 1:0] wdata
);
    logic [ENTRY_BITS - 1:0] lanes;
    lanes = expand_lanes(mask);
    model_data[addr]  = (model_data[addr] & ~lanes) | (wdata & lanes);
    model_known[addr] = model_known[addr] | mask;
    if (mask != '0)
    begin
        model_valid[addr] = 1'b1;
    end
endtask

// lanes never written hold unknown data, so only written lanes are compared.
task automatic check_data(
    input string                   name,
    input logic [ENTRY_BITS - 1:0] got,
    input logic [ENTRY_BITS - 1:0] exp,
    input logic [ENTRY_BITS - 1:0] care
);
    if ((got & care) !== (exp & care))
    begin
        $display("** Error at time %0t: %s got %h expected %h", $time, name, got, exp);
        fail_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("** Error at time %0t: %s got %b expected %b", $time, name, got, exp);
        fail_run();
    end
endtask

task automatic check_grant(
    input logic  exp_en,
    input prio_e exp_winner,
    input logic  got0,
    input logic  got1
);
    logic exp0;
    logic exp1;
    exp0 = exp_en && (exp_winner == prio_client0);
    exp1 = exp_en && (exp_winner == prio_client1);
    if ({got1, got0} !== {exp1, exp0})
    begin
        $display("** Error at time %0t: c1_grant,c0_grant got %b%b expected %b%b",
                 $time, got1, got0, exp1, exp0);
        fail_run();
    end
endtask

`endif

// File: test/store_tb.sv
`timescale 1ns/1ps

module store_tb
    import store_pkg::*;
();

    localparam int ENTRY_BITS   = 64;
    localparam int NUM_SET      = 64;
    localparam int ADDR_BITS    = $clog2(NUM_SET);
    localparam int MASK_BITS    = ENTRY_BITS / byte_len;
    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_CYCLES  = 2000;
    localparam int LIMIT_NS     = (RESET_CYCLES + NUM_SET + RAND_CYCLES + 50) * CLK_NS;

    logic                    clk_in = 1'b0;
    logic                    reset_in;

    logic                    cl_req   [2];
    store_op_e               cl_op    [2];
    logic [ADDR_BITS - 1:0]  cl_addr  [2];
    logic [MASK_BITS - 1:0]  cl_mask  [2];
    logic [ENTRY_BITS - 1:0] cl_wdata [2];
    logic                    last_grant [2];

    logic                    b_en;
    logic [MASK_BITS - 1:0]  b_mask;
    logic [ADDR_BITS - 1:0]  b_addr;
    logic [ENTRY_BITS - 1:0] b_wdata;

    logic                    c0_grant;
    logic                    c0_rsp_valid;
    logic [ENTRY_BITS - 1:0] c0_rdata;
    logic                    c0_hit;
    logic                    c1_grant;
    logic                    c1_rsp_valid;
    logic [ENTRY_BITS - 1:0] c1_rdata;
    logic                    c1_hit;
    logic [ENTRY_BITS - 1:0] b_rdata;
    logic                    b_hit;
    logic                    b_rsp_valid;

    // responses expected at the next edge.
    logic                    exp_a_valid;
    logic                    exp_a_owner;
    logic [ENTRY_BITS - 1:0] exp_a_data;
    logic [ENTRY_BITS - 1:0] exp_a_care;
    logic                    exp_a_hit;
    logic                    exp_b_valid;
    logic [ENTRY_BITS - 1:0] exp_b_data;
    logic [ENTRY_BITS - 1:0] exp_b_care;
    logic                    exp_b_hit;

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "stopped at the first mismatch");
    endtask

    `include "store_tb_util.svh"

    always #(CLK_NS / 2) clk_in = ~clk_in;

    shared_store_top #(
        .ENTRY_BITS (ENTRY_BITS),
        .NUM_SET    (NUM_SET)
    ) u_dut (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .c0_req       (cl_req[0]),
        .c0_op        (cl_op[0]),
        .c0_addr      (cl_addr[0]),
        .c0_mask      (cl_mask[0]),
        .c0_wdata     (cl_wdata[0]),
        .c0_grant     (c0_grant),
        .c0_rsp_valid (c0_rsp_valid),
        .c0_rdata     (c0_rdata),
        .c0_hit       (c0_hit),
        .c1_req       (cl_req[1]),
        .c1_op        (cl_op[1]),
        .c1_addr      (cl_addr[1]),
        .c1_mask      (cl_mask[1]),
        .c1_wdata     (cl_wdata[1]),
        .c1_grant     (c1_grant),
        .c1_rsp_valid (c1_rsp_valid),
        .c1_rdata     (c1_rdata),
        .c1_hit       (c1_hit),
        .b_en         (b_en),
        .b_mask       (b_mask),
        .b_addr       (b_addr),
        .b_wdata      (b_wdata),
        .b_rdata      (b_rdata),
        .b_hit        (b_hit),
        .b_rsp_valid  (b_rsp_valid)
    );

    function automatic prio_e winner_of(input logic req0, input logic req1, input prio_e prio);
        if (req0 && req1)
        begin
            return prio;
        end
        return req1 ? prio_client1 : prio_client0;
    endfunction

    task automatic check_responses();
        check_flag("c0_rsp_valid", c0_rsp_valid, exp_a_valid & ~exp_a_owner);
        check_flag("c1_rsp_valid", c1_rsp_valid, exp_a_valid & exp_a_owner);
        check_flag("c0_hit", c0_hit, exp_a_valid & ~exp_a_owner & exp_a_hit);
        check_flag("c1_hit", c1_hit, exp_a_valid & exp_a_owner & exp_a_hit);
        if (exp_a_valid && !exp_a_owner)
        begin
            check_data("c0_rdata", c0_rdata, exp_a_data, exp_a_care);
        end
        if (exp_a_valid && exp_a_owner)
        begin
            check_data("c1_rdata", c1_rdata, exp_a_data, exp_a_care);
        end
        check_flag("b_rsp_valid", b_rsp_valid, exp_b_valid);
        check_flag("b_hit", b_hit, exp_b_valid & exp_b_hit);
        if (exp_b_valid)
        begin
            check_data("b_rdata", b_rdata, exp_b_data, exp_b_care);
        end
    endtask

    // first pass reads every set on both ports before anything is written.
    task automatic pick_sweep_stimulus(input logic [ADDR_BITS - 1:0] set);
        cl_req[0]  = 1'b1;
        cl_op[0]   = op_read;
        cl_addr[0] = set;
        cl_req[1]  = 1'b0;
        b_en       = 1'b1;
        b_mask     = '0;
        b_addr     = ~set;
    endtask

    task automatic pick_random_stimulus();
        logic [31:0] rnd;
        prio_e       a_win;
        logic        w;
        logic        a_wr;
        for (int i = 0; i < 2; i++)
        begin
            // a waiting client holds its request.
            if (!cl_req[i] || last_grant[i])
            begin
                rnd         = next_random();
                cl_req[i]   = (rnd[1:0] != 2'b00);
                cl_op[i]    = rnd[2] ? op_write : op_read;
                cl_addr[i]  = rnd[8 +: ADDR_BITS];
                cl_mask[i]  = rnd[16 +: MASK_BITS];
                cl_wdata[i] = {next_random(), next_random()};
            end
        end
        rnd     = next_random();
        b_en    = rnd[0];
        b_mask  = rnd[1] ? rnd[8 +: MASK_BITS] : '0;
        b_addr  = rnd[16 +: ADDR_BITS];
        b_wdata = {next_random(), next_random()};
        // no same-set writes from both ports in one cycle.
        a_win = winner_of(cl_req[0], cl_req[1], model_prio);
        w     = (a_win == prio_client1);
        a_wr  = cl_req[w] && (cl_op[w] == op_write) && (cl_mask[w] != '0);
        if (a_wr && b_en && (b_mask != '0) && (b_addr == cl_addr[w]))
        begin
            b_addr = b_addr + ADDR_BITS'(1);
        end
    endtask

    task automatic predict_and_check_grants();
        logic                   a_en;
        prio_e                  a_win;
        logic                   w;
        logic [ADDR_BITS - 1:0] a_addr;
        logic [MASK_BITS - 1:0] a_mask;
        a_en  = cl_req[0] | cl_req[1];
        a_win = winner_of(cl_req[0], cl_req[1], model_prio);
        w     = (a_win == prio_client1);
        check_grant(a_en, a_win, c0_grant, c1_grant);
        last_grant[0] = a_en && !w;
        last_grant[1] = a_en && w;
        a_addr = cl_addr[w];
        a_mask = (cl_op[w] == op_write) ? cl_mask[w] : '0;

        // read-first. both responses see the state from before this edge.
        exp_a_valid = a_en;
        exp_a_owner = w;
        exp_a_data  = model_data[a_addr];
        exp_a_care  = expand_lanes(model_known[a_addr]);
        exp_a_hit   = model_valid[a_addr];
        exp_b_valid = b_en;
        exp_b_data  = model_data[b_addr];
        exp_b_care  = expand_lanes(model_known[b_addr]);
        exp_b_hit   = model_valid[b_addr];

        if (a_en)
        begin
            apply_write(a_addr, a_mask, cl_wdata[w]);
            model_prio = w ? prio_client0 : prio_client1;
        end
        if (b_en)
        begin
            apply_write(b_addr, b_mask, b_wdata);
        end
    endtask

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns before the test finished", LIMIT_NS);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial
    begin
        rng_state = 32'd46;
        reset_in  = 1'b1;
        for (int i = 0; i < 2; i++)
        begin
            cl_req[i]     = 1'b0;
            cl_op[i]      = op_read;
            cl_addr[i]    = '0;
            cl_mask[i]    = '0;
            cl_wdata[i]   = '0;
            last_grant[i] = 1'b0;
        end
        b_en    = 1'b0;
        b_mask  = '0;
        b_addr  = '0;
        b_wdata = '0;
        for (int s = 0; s < NUM_SET; s++)
        begin
            model_data[s]  = '0;
            model_known[s] = '0;
            model_valid[s] = 1'b0;
        end
        model_prio    = prio_client0;
        exp_a_valid   = 1'b0;
        exp_a_owner   = 1'b0;
        exp_a_data    = '0;
        exp_a_care    = '0;
        exp_a_hit     = 1'b0;
        exp_b_valid   = 1'b0;
        exp_b_data    = '0;
        exp_b_care    = '0;
        exp_b_hit     = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;

        for (int s = 0; s < NUM_SET; s++)
        begin
            @(negedge clk_in);
            check_responses();
            pick_sweep_stimulus(ADDR_BITS'(s));
            #1;
            predict_and_check_grants();
        end

        repeat (RAND_CYCLES)
        begin
            @(negedge clk_in);
            check_responses();
            pick_random_stimulus();
            #1;
            predict_and_check_grants();
        end

        @(negedge clk_in);
        check_responses();
        cl_req[0] = 1'b0;
        cl_req[1] = 1'b0;
        b_en      = 1'b0;

        $display("** PASS **");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+test
source/store_pkg.sv
source/dual_port_blockram.sv
source/port_arbiter.sv
source/response_router.sv
source/shared_store_top.sv
test/store_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module shared_store_top

sim:
	verilator --binary --timing -j 0 -f filelist.f --top-module store_tb \
		-Mdir $(OBJ_DIR) -o Vstore_tb
	./$(OBJ_DIR)/Vstore_tb

clean:
	rm -rf $(OBJ_DIR)
